/* src/mcu_defs.svh */
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// bus geometry
`define MCU_WB_ADR_W        6               // word address width
`define MCU_DATA_W          32              // data word width

// register map, word addresses
`define MCU_REG_GPO         6'h00           // gpio output
`define MCU_REG_GPD         6'h01           // gpio direction
`define MCU_REG_GPI         6'h02           // gpio input, read only
`define MCU_REG_PWM_DUTY    6'h03           // pwm duty
`define MCU_REG_PWM_DIV     6'h04           // pwm prescaler reload
`define MCU_REG_SCAN_BASE   6'h10           // 16 scan regs, 0x10..0x1f

// pwm prescaler
`define MCU_PWM_DIV_W       16              // prescaler width

// display multiplexing
`define MCU_SEG_SCAN_DIV    64              // clocks per digit, short for sim

`endif

/* src/mcu_pkg.sv */
`default_nettype none

`include "mcu_defs.svh"

package mcu_pkg;

    // plain vectors with a meaning
    typedef logic   [`MCU_WB_ADR_W-1 : 0]   wb_adr_t;       // wishbone word address
    typedef logic   [`MCU_DATA_W-1 : 0]     wb_data_t;      // wishbone data word
    typedef logic   [7 : 0]                 gpio_t;         // gpio pin vector
    typedef logic   [7 : 0]                 pwm_duty_t;     // duty in 1/256 steps
    typedef logic   [`MCU_PWM_DIV_W-1 : 0]  pwm_div_t;      // prescaler reload
    typedef logic   [3 : 0]                 scan_addr_t;    // scan reg index
    typedef logic   [7 : 0]                 seg_t;          // a..g in 0..6, dp in 7

    // wishbone classic request, master to slave
    typedef struct packed {
        logic       cyc;                                    // bus cycle
        logic       stb;                                    // strobe
        logic       we;                                     // write enable
        wb_adr_t    adr;                                    // word address
        wb_data_t   dat;                                    // write data
    } wb_req_t;

    // wishbone classic response, slave to master
    typedef struct packed {
        logic       ack;                                    // one cycle ack
        wb_data_t   dat;                                    // read data, valid with ack
    } wb_rsp_t;

endpackage : mcu_pkg

`default_nettype wire

/* src/wb_periph_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mcu_defs.svh"

module wb_periph_regs
(
    input   logic   [0 : 0]         clk,        // clock
    input   logic   [0 : 0]         arst_n,     // async reset, active low
    input   mcu_pkg::wb_req_t       wb_req,     // wishbone request
    output  mcu_pkg::wb_rsp_t       wb_rsp,     // wishbone response
    input   mcu_pkg::gpio_t         gpi,        // gpio input pins
    output  mcu_pkg::gpio_t         gpo,        // gpio output register
    output  mcu_pkg::gpio_t         gpd,        // gpio direction register
    output  mcu_pkg::pwm_duty_t     pwm_duty,   // pwm duty register
    output  mcu_pkg::pwm_div_t      pwm_div,    // pwm prescaler register
    input   mcu_pkg::scan_addr_t    scan_addr,  // scan port index
    output  mcu_pkg::wb_data_t      scan_data   // scan port data
);

    localparam  mcu_pkg::wb_adr_t   SCAN_BASE = `MCU_REG_SCAN_BASE;
    localparam  int                 ADR_MSB   = `MCU_WB_ADR_W - 1;

    logic   [0 : 0]         req_new;    // cyc & stb, not the tail of an acked one
    logic   [0 : 0]         wr_en;      // write strobe, lands with ack
    logic   [0 : 0]         scan_hit;   // address inside scan window
    mcu_pkg::scan_addr_t    scan_idx;   // scan reg picked by the bus
    mcu_pkg::wb_data_t      rd_mux;     // read data before the register
    logic   [0 : 0]         ack_q;      // ack flop
    mcu_pkg::wb_data_t      rdata_q;    // read data flop
    mcu_pkg::wb_data_t      scan_regs [16];     // debug image of a core regfile

    // request still held during ack, so mask it off for one cycle
    assign req_new  = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_en    = req_new && wb_req.we;
    assign scan_hit = wb_req.adr[ADR_MSB : 4] == SCAN_BASE[ADR_MSB : 4];
    assign scan_idx = wb_req.adr[3 : 0];    // low nibble picks the scan reg

    assign wb_rsp    = '{ack : ack_q, dat : rdata_q};
    assign scan_data = scan_regs[scan_addr];    // combinational debug port

    // read decode, narrow regs zero extended
    always_comb
    begin
        rd_mux = '0;                                    // unmapped reads as zero
        if (scan_hit)
        begin
            rd_mux = scan_regs[scan_idx];
        end
        else
        begin
            case (wb_req.adr)
                `MCU_REG_GPO        : rd_mux[$bits(gpo)-1 : 0]      = gpo;
                `MCU_REG_GPD        : rd_mux[$bits(gpd)-1 : 0]      = gpd;
                `MCU_REG_GPI        : rd_mux[$bits(gpi)-1 : 0]      = gpi;  // live pins
                `MCU_REG_PWM_DUTY   : rd_mux[$bits(pwm_duty)-1 : 0] = pwm_duty;
                `MCU_REG_PWM_DIV    : rd_mux[$bits(pwm_div)-1 : 0]  = pwm_div;
                default             : ;
            endcase
        end
    end

    // handshake and control regs
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ack_q    <= '0;
            gpo      <= '0;
            gpd      <= '0;
            pwm_duty <= '0;
            pwm_div  <= '0;
        end
        else
        begin
            ack_q <= req_new;                           // one cycle after sampling
            if (wr_en)
            begin
                case (wb_req.adr)
                    `MCU_REG_GPO        : gpo      <= wb_req.dat[$bits(gpo)-1 : 0];
                    `MCU_REG_GPD        : gpd      <= wb_req.dat[$bits(gpd)-1 : 0];
                    `MCU_REG_PWM_DUTY   : pwm_duty <= wb_req.dat[$bits(pwm_duty)-1 : 0];
                    `MCU_REG_PWM_DIV    : pwm_div  <= wb_req.dat[$bits(pwm_div)-1 : 0];
                    default             : ;             // gpi and holes ignore writes
                endcase
            end
        end
    end

    // read data, only meaningful alongside ack
    always_ff @(posedge clk)
    begin
        if (req_new)
        begin
            rdata_q <= rd_mux;
        end
    end

    // scan regs, cleared so the display starts blank at 0000
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 16; i++)
            begin
                scan_regs[i] <= '0;
            end
        end
        else if (wr_en && scan_hit)
        begin
            scan_regs[scan_idx] <= wb_req.dat;
        end
    end

    // master holding stb through ack must not get a second ack
    ack_single_cycle : assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack
    );

    // every ack answers a request seen on the previous edge
    ack_after_request : assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    );

endmodule : wb_periph_regs

`default_nettype wire

/* src/pwm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pwm_gen
(
    input   logic   [0 : 0]         clk,        // clock
    input   logic   [0 : 0]         arst_n,     // async reset, active low
    input   mcu_pkg::pwm_duty_t     duty,       // high phases per 256
    input   mcu_pkg::pwm_div_t      div,        // prescaler reload, phase = div+1 clocks
    output  logic   [0 : 0]         pwm         // registered pwm pin
);

    mcu_pkg::pwm_div_t      pre_cnt;    // prescaler, 0..div
    mcu_pkg::pwm_duty_t     phase;      // phase within the 256 step period
    logic   [0 : 0]         pre_wrap;   // last clock of a phase

    // >= so a smaller divider written mid count ends the phase at once
    assign pre_wrap = pre_cnt >= div;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pre_cnt <= '0;
            phase   <= '0;
            pwm     <= '0;
        end
        else
        begin
            if (pre_wrap)
            begin
                pre_cnt <= '0;
                phase   <= phase + 1'b1;                // wraps 255 -> 0
            end
            else
            begin
                pre_cnt <= pre_cnt + 1'b1;
            end
            pwm <= phase < duty;                        // duty 255 leaves phase 255 low
        end
    end

    // output flop lags duty by one edge, hence the next-cycle check
    pwm_off_at_zero_duty : assert property (
        @(posedge clk) disable iff (!arst_n)
        (duty == '0) |=> !pwm
    );

endmodule : pwm_gen

`default_nettype wire

/* src/seg7_dynamic.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mcu_defs.svh"

module seg7_dynamic
#(
    parameter   bit     COMMON_ANODE = 1'b1             // 1: active low segs and digits
)
(
    input   logic   [0 : 0]         clk,        // clock
    input   logic   [0 : 0]         arst_n,     // async reset, active low
    input   mcu_pkg::wb_data_t      value,      // word to show, low 16 bits used
    output  mcu_pkg::seg_t          seven_seg,  // segment lines
    output  logic   [3 : 0]         dig         // digit selects
);

    localparam  int             SCAN_DIV = `MCU_SEG_SCAN_DIV;
    localparam  int             DIV_W    = $clog2(SCAN_DIV);
    localparam  mcu_pkg::seg_t  SEG_POL  = {8{COMMON_ANODE}};  // xor mask for polarity
    localparam  logic [3 : 0]   DIG_POL  = {4{COMMON_ANODE}};

    logic   [DIV_W-1 : 0]   div_cnt;    // clocks on the current digit
    logic   [1 : 0]         dig_idx;    // digit being driven
    logic   [3 : 0]         nibble;     // hex nibble for that digit
    mcu_pkg::seg_t          font;       // active high pattern
    logic   [3 : 0]         dig_sel;    // active high one-hot select

    assign nibble  = value[dig_idx*4 +: 4];
    assign dig_sel = 4'b0001 << dig_idx;

    // hex font, dp off
    always_comb
    begin
        case (nibble)
            4'h0    : font = 8'h3f;
            4'h1    : font = 8'h06;
            4'h2    : font = 8'h5b;
            4'h3    : font = 8'h4f;
            4'h4    : font = 8'h66;
            4'h5    : font = 8'h6d;
            4'h6    : font = 8'h7d;
            4'h7    : font = 8'h07;
            4'h8    : font = 8'h7f;
            4'h9    : font = 8'h6f;
            4'ha    : font = 8'h77;
            4'hb    : font = 8'h7c;                     // lower case b
            4'hc    : font = 8'h39;
            4'hd    : font = 8'h5e;                     // lower case d
            4'he    : font = 8'h79;
            default : font = 8'h71;                     // F
        endcase
    end

    // digit rotation 0,1,2,3 and output regs
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt   <= '0;
            dig_idx   <= '0;
            seven_seg <= 8'h3f ^ SEG_POL;               // "0" on digit 0
            dig       <= 4'b0001 ^ DIG_POL;
        end
        else
        begin
            if (div_cnt == DIV_W'(SCAN_DIV - 1))
            begin
                div_cnt <= '0;
                dig_idx <= dig_idx + 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
            seven_seg <= font ^ SEG_POL;                // segs and select move together
            dig       <= dig_sel ^ DIG_POL;
        end
    end

    // one tube lit at a time, whatever the polarity
    one_digit_active : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot(dig ^ DIG_POL)
    );

endmodule : seg7_dynamic

`default_nettype wire

/* src/board_top.sv */
`timescale 1ns/1ns
`default_nettype none

module board_top
(
    input   logic   [0 : 0]         clk50mhz,   // board oscillator
    input   logic   [0 : 0]         arst_n,     // reset key, active low
    input   logic   [3 : 0]         key,        // scan register select
    input   mcu_pkg::wb_req_t       wb_req,     // data bus from the core side
    output  mcu_pkg::wb_rsp_t       wb_rsp,     // data bus response
    input   mcu_pkg::gpio_t         gpi,        // gpio input pins
    output  mcu_pkg::gpio_t         gpio_out,   // gpio output values
    output  mcu_pkg::gpio_t         gpio_oe,    // gpio output enables
    output  logic   [3 : 0]         led,        // board leds
    output  logic   [0 : 0]         pwm,        // pwm pin
    output  mcu_pkg::seg_t          hex0,       // seven segment lines
    output  logic   [3 : 0]         dig         // digit selects
);

    logic   [0 : 0]         clk;        // core clock
    mcu_pkg::gpio_t         gpo;        // gpio output reg
    mcu_pkg::gpio_t         gpd;        // gpio direction reg
    mcu_pkg::pwm_duty_t     pwm_duty;   // pwm duty reg
    mcu_pkg::pwm_div_t      pwm_div;    // pwm prescaler reg
    mcu_pkg::wb_data_t      scan_data;  // scanned register value

    assign clk      = clk50mhz;
    assign gpio_out = gpo;
    assign gpio_oe  = gpd;
    assign led      = gpo[0 +: 4];      // low gpio bits on the leds

    // register block
    wb_periph_regs
    u_regs
    (
        .clk        ( clk       ),  // clock
        .arst_n     ( arst_n    ),  // reset
        .wb_req     ( wb_req    ),  // bus request
        .wb_rsp     ( wb_rsp    ),  // bus response
        .gpi        ( gpi       ),  // gpio input
        .gpo        ( gpo       ),  // gpio output
        .gpd        ( gpd       ),  // gpio direction
        .pwm_duty   ( pwm_duty  ),  // pwm duty
        .pwm_div    ( pwm_div   ),  // pwm prescaler
        .scan_addr  ( key       ),  // keys pick the scanned reg
        .scan_data  ( scan_data )   // scanned reg value
    );

    // pwm generator
    pwm_gen
    u_pwm
    (
        .clk        ( clk       ),  // clock
        .arst_n     ( arst_n    ),  // reset
        .duty       ( pwm_duty  ),  // duty
        .div        ( pwm_div   ),  // prescaler reload
        .pwm        ( pwm       )   // pwm pin
    );

    // debug display, common anode tubes on this board
    seg7_dynamic
    #(
        .COMMON_ANODE   ( 1'b1      )   // active low lines
    )
    u_seg
    (
        .clk        ( clk       ),  // clock
        .arst_n     ( arst_n    ),  // reset
        .value      ( scan_data ),  // value to show
        .seven_seg  ( hex0      ),  // segment lines
        .dig        ( dig       )   // digit selects
    );

endmodule : board_top

`default_nettype wire

/* dv/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int                     err_cnt     = 0;                // failed checks
logic   [31 : 0]        lfsr_state  = 32'd25;           // lfsr seed
mcu_pkg::gpio_t         shadow_gpo  = '0;               // expected gpo
mcu_pkg::gpio_t         shadow_gpd  = '0;               // expected gpd
mcu_pkg::pwm_duty_t     shadow_duty = '0;               // expected duty
mcu_pkg::pwm_div_t      shadow_div  = '0;               // expected divider
mcu_pkg::wb_data_t      shadow_scan [16] = '{default: '0};  // expected scan regs

// right shifting galois form of x^32+x^22+x^2+x+1
function automatic logic [31 : 0] lfsr_next(input logic [31 : 0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// msb first with one lfsr step per bit taken
function automatic logic [31 : 0] rand_bits(input int n);
    logic   [31 : 0]    r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        r          = {r[30 : 0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
endfunction

function automatic logic in_scan_window(input mcu_pkg::wb_adr_t adr);
    return (adr & 6'h30) == `MCU_REG_SCAN_BASE;         // 0x10..0x1f
endfunction

function automatic logic is_mapped(input mcu_pkg::wb_adr_t adr);
    case (adr)
        `MCU_REG_GPO, `MCU_REG_GPD, `MCU_REG_GPI,
        `MCU_REG_PWM_DUTY, `MCU_REG_PWM_DIV : return 1'b1;
        default                             : return in_scan_window(adr);
    endcase
endfunction

// shadow update where narrow regs keep their low bits
function automatic void shadow_write(input mcu_pkg::wb_adr_t adr, input mcu_pkg::wb_data_t dat);
    case (adr)
        `MCU_REG_GPO        : shadow_gpo  = dat[7 : 0];
        `MCU_REG_GPD        : shadow_gpd  = dat[7 : 0];
        `MCU_REG_PWM_DUTY   : shadow_duty = dat[7 : 0];
        `MCU_REG_PWM_DIV    : shadow_div  = dat[15 : 0];
        default             :
            if (in_scan_window(adr))
            begin
                shadow_scan[adr[3 : 0]] = dat;
            end                                         // gpi and holes drop the write
    endcase
endfunction

// zero extended read data prediction
function automatic logic [31 : 0] reg_ref(input mcu_pkg::wb_adr_t adr);
    case (adr)
        `MCU_REG_GPO        : return 32'(shadow_gpo);
        `MCU_REG_GPD        : return 32'(shadow_gpd);
        `MCU_REG_GPI        : return 32'(gpi);          // pins as driven
        `MCU_REG_PWM_DUTY   : return 32'(shadow_duty);
        `MCU_REG_PWM_DIV    : return 32'(shadow_div);
        default             : return in_scan_window(adr) ? shadow_scan[adr[3 : 0]] : 32'h0;
    endcase
endfunction

// standard gfedcba hex font inverted for common anode with dp dark
function automatic mcu_pkg::seg_t seg_ref(input logic [3 : 0] nib);
    logic   [7 : 0]     font [16] = '{8'h3f, 8'h06, 8'h5b, 8'h4f,
                                      8'h66, 8'h6d, 8'h7d, 8'h07,
                                      8'h7f, 8'h6f, 8'h77, 8'h7c,
                                      8'h39, 8'h5e, 8'h79, 8'h71};
    return ~font[nib];
endfunction

// high clocks in one full period
function automatic int pwm_high_ref(input mcu_pkg::pwm_duty_t duty, input mcu_pkg::pwm_div_t div);
    return int'(duty) * (int'(div) + 1);
endfunction

task automatic check(input string name, input logic [31 : 0] got, input logic [31 : 0] exp);
    if (got !== exp)
    begin
        err_cnt++;
        $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first failed check");
    end
endtask

`endif

/* dv/tb_board_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mcu_defs.svh"

module tb_board_top;

    localparam int  CLK_HALF     = 5;                               // 10 ns period
    localparam int  ACK_LIMIT    = 8;                               // ack wait bound
    localparam int  DIGIT_SETTLE = 4 * `MCU_SEG_SCAN_DIV + 2;      // full rotation + out reg
    localparam int  N_PWM        = 6;
    localparam int  N_KEY        = 4;
    localparam int  BUS_CYCLES   = 250 * 4;                         // about 3 clk per transfer
    localparam int  PWM_CYCLES   = N_PWM * 3 * 256 * 4;             // div up to 3
    localparam int  DISP_CYCLES  = N_KEY * 2 * 5 * DIGIT_SETTLE;
    localparam int  WATCHDOG_NS  = 2 * (10 + BUS_CYCLES + PWM_CYCLES + DISP_CYCLES) * 2 * CLK_HALF;

    logic   [0 : 0]         clk;
    logic   [0 : 0]         arst_n;
    logic   [3 : 0]         key;
    mcu_pkg::wb_req_t       wb_req;
    mcu_pkg::wb_rsp_t       wb_rsp;
    mcu_pkg::gpio_t         gpi;
    mcu_pkg::gpio_t         gpio_out;
    mcu_pkg::gpio_t         gpio_oe;
    logic   [3 : 0]         led;
    logic   [0 : 0]         pwm;
    mcu_pkg::seg_t          hex0;
    logic   [3 : 0]         dig;

    `include "tb_model.svh"

    board_top
    u_dut
    (
        .clk50mhz   ( clk       ),
        .arst_n     ( arst_n    ),
        .key        ( key       ),
        .wb_req     ( wb_req    ),
        .wb_rsp     ( wb_rsp    ),
        .gpi        ( gpi       ),
        .gpio_out   ( gpio_out  ),
        .gpio_oe    ( gpio_oe   ),
        .led        ( led       ),
        .pwm        ( pwm       ),
        .hex0       ( hex0      ),
        .dig        ( dig       )
    );

    always #CLK_HALF clk = ~clk;

    // one transfer with ack expected at the first falling edge after the request
    task automatic bus_xfer(input logic we, input mcu_pkg::wb_adr_t adr,
                            input mcu_pkg::wb_data_t dat, output mcu_pkg::wb_data_t rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_rsp.ack && waited < ACK_LIMIT);
        check("ack latency", 32'(waited), 32'd1);
        rdat = wb_rsp.dat;
        @(negedge clk);                                 // request held over the next edge
        check("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);    // single cycle ack
        wb_req = '0;                                    // drop cyc and stb
    endtask

    task automatic bus_write(input mcu_pkg::wb_adr_t adr, input mcu_pkg::wb_data_t dat);
        mcu_pkg::wb_data_t  rd;
        bus_xfer(1'b1, adr, dat, rd);
        shadow_write(adr, dat);
    endtask

    task automatic read_compare(input mcu_pkg::wb_adr_t adr);
        mcu_pkg::wb_data_t  rd;
        bus_xfer(1'b0, adr, '0, rd);
        check($sformatf("wb_rsp.dat[%02h]", adr), rd, reg_ref(adr));
    endtask

    task automatic read_all_mapped();
        read_compare(`MCU_REG_GPO);
        read_compare(`MCU_REG_GPD);
        read_compare(`MCU_REG_PWM_DUTY);
        read_compare(`MCU_REG_PWM_DIV);
        for (int i = 0; i < 16; i++)
        begin
            read_compare(`MCU_REG_SCAN_BASE | 6'(i));
        end
    endtask

    task automatic check_gpio();
        check("gpio_out", 32'(gpio_out), 32'(shadow_gpo));
        check("gpio_oe", 32'(gpio_oe), 32'(shadow_gpd));
        check("led", 32'(led), 32'(shadow_gpo[3 : 0]));
    endtask

    // count over one full period once the new settings have run a period
    task automatic check_pwm(input mcu_pkg::pwm_duty_t duty, input mcu_pkg::pwm_div_t div);
        int high;
        int period;
        period = 256 * (int'(div) + 1);
        high   = 0;
        bus_write(`MCU_REG_PWM_DIV, 32'(div));
        bus_write(`MCU_REG_PWM_DUTY, 32'(duty));
        repeat (period + 2) @(negedge clk);
        repeat (period)
        begin
            @(negedge clk);
            if (pwm)
            begin
                high++;
            end
        end
        check($sformatf("pwm high, duty %0d div %0d", duty, div), 32'(high),
              32'(pwm_high_ref(duty, div)));
    endtask

    // each digit checked as its select goes low
    task automatic check_display(input logic [3 : 0] k);
        int             waited;
        logic   [3 : 0] want_dig;
        for (int i = 0; i < 4; i++)
        begin
            want_dig = ~(4'b0001 << i);
            waited   = 0;
            while (dig !== want_dig && waited < DIGIT_SETTLE)
            begin
                @(negedge clk);
                waited++;
            end
            check("dig", 32'(dig), 32'(want_dig));
            check($sformatf("hex0 digit %0d", i), 32'(hex0),
                  32'(seg_ref(shadow_scan[k][i*4 +: 4])));
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the test sequence did not complete");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial
    begin
        logic   [3 : 0] k;
        clk    = 1'b0;
        arst_n = 1'b0;
        key    = '0;
        gpi    = '0;
        wb_req = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // reset state
        check("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);
        check_gpio();
        check("pwm", 32'(pwm), 32'd0);
        check("dig active count", 32'($countones(~dig)), 32'd1);
        check("hex0", 32'(hex0), 32'(seg_ref(4'h0)));

        // register map
        bus_write(`MCU_REG_GPO, rand_bits(32));
        bus_write(`MCU_REG_GPD, rand_bits(32));
        bus_write(`MCU_REG_PWM_DUTY, rand_bits(32));
        bus_write(`MCU_REG_PWM_DIV, rand_bits(32));
        for (int i = 0; i < 16; i++)
        begin
            bus_write(`MCU_REG_SCAN_BASE | 6'(i), rand_bits(32));
        end
        read_all_mapped();
        check_gpio();
        bus_write(`MCU_REG_GPI, rand_bits(32));         // read only so the write is dropped
        for (int a = 0; a < (1 << `MCU_WB_ADR_W); a++)
        begin
            if (!is_mapped(6'(a)))
            begin
                bus_write(6'(a), rand_bits(32));
                read_compare(6'(a));                    // holes read zero
            end
        end
        read_all_mapped();                              // nothing moved

        // gpio pins
        for (int i = 0; i < 4; i++)
        begin
            gpi = mcu_pkg::gpio_t'(rand_bits(8));
            read_compare(`MCU_REG_GPI);
            bus_write(`MCU_REG_GPO, rand_bits(8));
            bus_write(`MCU_REG_GPD, rand_bits(8));
            check_gpio();
        end

        // pwm duty with small dividers
        check_pwm(8'd0, mcu_pkg::pwm_div_t'(rand_bits(2)));
        check_pwm(8'd255, mcu_pkg::pwm_div_t'(rand_bits(2)));
        for (int i = 2; i < N_PWM; i++)
        begin
            check_pwm(mcu_pkg::pwm_duty_t'(rand_bits(8)), mcu_pkg::pwm_div_t'(rand_bits(2)));
        end

        // debug display
        for (int i = 0; i < N_KEY; i++)
        begin
            k   = 4'(rand_bits(4));
            key = k;
            repeat (DIGIT_SETTLE) @(negedge clk);
            check_display(k);
            bus_write(`MCU_REG_SCAN_BASE | {2'b00, k}, rand_bits(32));
            repeat (DIGIT_SETTLE) @(negedge clk);
            check_display(k);                           // follows the rewrite
        end

        if (err_cnt == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

endmodule : tb_board_top

`default_nettype wire

/* compile.f */
+incdir+src
+incdir+dv
src/mcu_pkg.sv
src/wb_periph_regs.sv
src/pwm_gen.sv
src/seg7_dynamic.sv
src/board_top.sv
dv/tb_board_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard src/*.svh dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^NO ERRORS$$' $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
